// ==== design/dl11_pkg.sv ====
/*
 * dl11 console serial line unit
 * shared types, iopage register addresses, csr bit positions,
 * interrupt vectors and line controller state encodings
 */
package dl11_pkg;

   typedef logic [12:0] iopage_addr_t;   // iopage byte address
   typedef logic [15:0] word_t;          // bus data word
   typedef logic [7:0]  byte_t;          // serial character
   typedef logic [7:0]  vector_t;        // interrupt vector

   // standard console addresses
   localparam iopage_addr_t RCSR_ADDR = 13'o17560;
   localparam iopage_addr_t RBUF_ADDR = 13'o17562;
   localparam iopage_addr_t XCSR_ADDR = 13'o17564;
   localparam iopage_addr_t XBUF_ADDR = 13'o17566;

   // same layout in rcsr and xcsr
   localparam int CSR_DONE_BIT = 7;
   localparam int CSR_IE_BIT   = 6;

   localparam vector_t RX_VECTOR = 8'o60;   // receive wins
   localparam vector_t TX_VECTOR = 8'o64;

   typedef enum logic [1:0] {
      tx_idle,
      tx_load,
      tx_busy
   } tx_state_t;

   typedef enum logic [1:0] {
      rx_wait,
      rx_unload,
      rx_full
   } rx_state_t;

endpackage

// ==== design/dl11_baud_timer.sv ====
/*
 * dl11 baud timer
 * divides clk into the 16x receive sample tick and the bit tick
 */
`timescale 1ns/1ps

module dl11_baud_timer #(
   parameter int unsigned SAMPLE_DIV = 1   // clk cycles per sample tick
) (
   input  logic clk,
   input  logic reset,
   output logic sample_tick,
   output logic bit_tick
);

   localparam int DIV_W = $clog2(SAMPLE_DIV + 1);

   logic [DIV_W-1:0] div_cnt;
   logic [3:0]       smp_cnt;   // 16 samples per bit

   assign sample_tick = (div_cnt == DIV_W'(SAMPLE_DIV - 1));
   assign bit_tick    = sample_tick && (smp_cnt == 4'd15);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         div_cnt <= '0;
         smp_cnt <= '0;
      end
      else if (sample_tick)
      begin
         div_cnt <= '0;
         smp_cnt <= smp_cnt + 4'd1;   // wraps every bit time
      end
      else
         div_cnt <= div_cnt + DIV_W'(1);
   end

endmodule

// ==== design/dl11_tx_shifter.sv ====
/*
 * dl11 transmit shifter
 * sends one 8N1 frame, lsb first, one bit per bit tick
 */
`timescale 1ns/1ps

module dl11_tx_shifter
   import dl11_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  bit_tick,
   input  logic  tx_load,
   input  byte_t tx_byte,
   output logic  txd,
   output logic  tx_busy
);

   localparam int FRAME_BITS = 10;   // start, 8 data, stop

   logic [FRAME_BITS-1:0] frame;
   logic [3:0]            bit_cnt;   // bits still to put on the line
   logic                  start;
   logic                  shift;

   assign start = tx_load && !tx_busy;
   assign shift = tx_busy && bit_tick;

   // frame register
   always_ff @(posedge clk)
   begin
      if (start)
         frame <= {1'b1, tx_byte, 1'b0};
      else if (shift)
         frame <= {1'b1, frame[FRAME_BITS-1:1]};   // fill with mark
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         txd     <= 1'b1;   // line idles at mark
         tx_busy <= 1'b0;
         bit_cnt <= '0;
      end
      else if (start)
      begin
         tx_busy <= 1'b1;
         bit_cnt <= 4'(FRAME_BITS);
      end
      else if (shift)
      begin
         if (bit_cnt != 4'd0)
         begin
            txd     <= frame[0];
            bit_cnt <= bit_cnt - 4'd1;
         end
         else
            tx_busy <= 1'b0;   // stop bit has had its full bit time
      end
   end

endmodule

// ==== design/dl11_rx_shifter.sv ====
/*
 * dl11 receive shifter
 * 16x oversampling receiver: start bit check at mid-bit, then one sample
 * per bit time; frames with a bad stop bit are discarded
 */
`timescale 1ns/1ps

module dl11_rx_shifter
   import dl11_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  sample_tick,
   input  logic  rxd,
   output byte_t rx_byte,
   output logic  rx_valid
);

   localparam logic [3:0] MID_SAMPLE = 4'd7;   // 8th tick after the edge
   localparam logic [3:0] STOP_BIT   = 4'd9;

   logic       rxd_meta;
   logic       rxd_sync;
   logic       rxd_prev;
   logic       active;
   logic [3:0] smp_cnt;
   logic [3:0] bit_cnt;     // 0 start, 1..8 data, 9 stop
   logic       mid;
   logic       start_edge;
   logic       data_bit;
   byte_t      shreg;

   assign start_edge = rxd_prev && !rxd_sync;
   assign mid        = active && sample_tick && (smp_cnt == MID_SAMPLE);
   assign data_bit   = (bit_cnt != 4'd0) && (bit_cnt != STOP_BIT);
   assign rx_byte    = shreg;

   // two flop synchronizer plus edge history
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end
      else
      begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   always_ff @(posedge clk)
   begin
      if (mid && data_bit)
         shreg <= {rxd_sync, shreg[7:1]};   // lsb arrives first
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         active   <= 1'b0;
         smp_cnt  <= '0;
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
      end
      else
      begin
         rx_valid <= 1'b0;
         if (!active)
         begin
            if (start_edge)
            begin
               active  <= 1'b1;
               smp_cnt <= '0;
               bit_cnt <= '0;
            end
         end
         else if (sample_tick)
         begin
            smp_cnt <= smp_cnt + 4'd1;
            if (mid)
            begin
               if (bit_cnt == 4'd0)
               begin
                  if (rxd_sync)
                     active <= 1'b0;   // glitch, not a start bit
                  else
                     bit_cnt <= 4'd1;
               end
               else if (bit_cnt == STOP_BIT)
               begin
                  active   <= 1'b0;
                  rx_valid <= rxd_sync;   // framing error drops the byte
               end
               else
                  bit_cnt <= bit_cnt + 4'd1;
            end
         end
      end
   end

endmodule

// ==== design/dl11_line_ctrl.sv ====
/*
 * dl11 line controller
 * transmit and receive sequencing, done flags and the two vectored
 * interrupt requests with receive priority
 */
`timescale 1ns/1ps

module dl11_line_ctrl
   import dl11_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    xbuf_wr,
   input  logic    rbuf_rd,
   input  logic    tx_busy,
   input  logic    rx_valid,
   input  logic    rx_ie,
   input  logic    tx_ie,
   input  logic    interrupt_ack,
   output logic    tx_load,
   output logic    rx_unload,
   output logic    tx_ready,
   output logic    rx_done,
   output logic    interrupt,
   output vector_t vector
);

   tx_state_t tx_state;
   tx_state_t tx_next;
   rx_state_t rx_state;
   rx_state_t rx_next;
   logic      tx_int;
   logic      rx_int;
   logic      tx_asserting;
   logic      rx_asserting;

   always_comb
   begin
      tx_next = tx_state;
      case (tx_state)
         tx_idle:           if (xbuf_wr) tx_next = dl11_pkg::tx_load;
         dl11_pkg::tx_load: if (tx_busy) tx_next = dl11_pkg::tx_busy;
         dl11_pkg::tx_busy: if (!tx_busy) tx_next = tx_idle;
         default:           tx_next = tx_idle;
      endcase
   end

   always_comb
   begin
      rx_next = rx_state;
      case (rx_state)
         rx_wait:             if (rx_valid) rx_next = dl11_pkg::rx_unload;
         dl11_pkg::rx_unload: rx_next = rx_full;
         rx_full:
         begin
            if (rx_valid)
               rx_next = dl11_pkg::rx_unload;   // new byte overwrites rbuf
            else if (rbuf_rd)
               rx_next = rx_wait;
         end
         default:             rx_next = rx_wait;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_state <= tx_idle;
         rx_state <= rx_wait;
      end
      else
      begin
         tx_state <= tx_next;
         rx_state <= rx_next;
      end
   end

   assign tx_load   = (tx_state == dl11_pkg::tx_load) && !tx_busy;   // single pulse
   assign rx_unload = (rx_state == dl11_pkg::rx_unload);
   assign tx_ready  = (tx_state == tx_idle);
   assign rx_done   = (rx_state == rx_full);

   assign tx_asserting = tx_ie && tx_int;
   assign rx_asserting = rx_ie && rx_int;
   assign interrupt    = tx_asserting || rx_asserting;
   assign vector       = rx_asserting ? RX_VECTOR :
                         tx_asserting ? TX_VECTOR : '0;

   // clear wins over set so an ack takes the request down
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_int <= 1'b1;   // ready transmitter requests at once
         rx_int <= 1'b0;
      end
      else
      begin
         if (xbuf_wr || (interrupt_ack && tx_asserting && !rx_asserting))
            tx_int <= 1'b0;
         else if (tx_ready)
            tx_int <= 1'b1;

         if (rbuf_rd || (interrupt_ack && rx_asserting))
            rx_int <= 1'b0;
         else if (rx_done)
            rx_int <= 1'b1;
      end
   end

endmodule

// ==== design/dl11_regs.sv ====
/*
 * dl11 register file
 * wishbone classic slave for rcsr, rbuf, xcsr and xbuf with byte lanes,
 * registered ack and the access strobes for the line controller
 */
`timescale 1ns/1ps

module dl11_regs
   import dl11_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  iopage_addr_t wb_adr,
   input  word_t        wb_dat_w,
   input  logic [1:0]   wb_sel,
   input  logic         wb_we,
   input  logic         wb_cyc,
   input  logic         wb_stb,
   input  logic         tx_ready,
   input  logic         rx_done,
   input  logic         rx_unload,
   input  byte_t        rx_byte,
   output word_t        wb_dat_r,
   output logic         wb_ack,
   output logic         xbuf_wr,
   output logic         rbuf_rd,
   output logic         rx_ie,
   output logic         tx_ie,
   output byte_t        xbuf_low
);

   logic  rcsr_hit;
   logic  rbuf_hit;
   logic  xcsr_hit;
   logic  xbuf_hit;
   logic  req;
   logic  wr;
   word_t reg_in;
   word_t rd_mux;
   word_t xbuf;
   byte_t rbuf;

   // odd addresses select the same word
   assign rcsr_hit = (wb_adr[12:1] == RCSR_ADDR[12:1]);
   assign rbuf_hit = (wb_adr[12:1] == RBUF_ADDR[12:1]);
   assign xcsr_hit = (wb_adr[12:1] == XCSR_ADDR[12:1]);
   assign xbuf_hit = (wb_adr[12:1] == XBUF_ADDR[12:1]);

   assign req = wb_cyc && wb_stb && !wb_ack &&
                (rcsr_hit || rbuf_hit || xcsr_hit || xbuf_hit);
   assign wr  = req && wb_we && (wb_sel != 2'b00);

   // high lane moves down for an odd byte write
   assign reg_in = (wb_adr[0] || (wb_sel == 2'b10)) ? {8'h00, wb_dat_w[15:8]} : wb_dat_w;

   assign xbuf_wr  = wr && xbuf_hit;
   assign rbuf_rd  = req && !wb_we && rbuf_hit;
   assign xbuf_low = xbuf[7:0];

   always_comb
   begin
      rd_mux = '0;
      if (rcsr_hit)
      begin
         rd_mux[CSR_DONE_BIT] = rx_done;
         rd_mux[CSR_IE_BIT]   = rx_ie;
      end
      else if (rbuf_hit)
         rd_mux[7:0] = rbuf;
      else if (xcsr_hit)
      begin
         rd_mux[CSR_DONE_BIT] = tx_ready;
         rd_mux[CSR_IE_BIT]   = tx_ie;
      end
      else if (xbuf_hit)
         rd_mux = xbuf;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wb_ack <= 1'b0;
         rx_ie  <= 1'b0;
         tx_ie  <= 1'b0;
      end
      else
      begin
         wb_ack <= req;   // one cycle, never for a miss
         if (wr && rcsr_hit)
            rx_ie <= reg_in[CSR_IE_BIT];
         if (wr && xcsr_hit)
            tx_ie <= reg_in[CSR_IE_BIT];
      end
   end

   always_ff @(posedge clk)
   begin
      if (req)
         wb_dat_r <= rd_mux;   // held for the ack cycle
      if (xbuf_wr)
         xbuf <= reg_in;
      if (rx_unload)
         rbuf <= rx_byte;
   end

endmodule

// ==== design/dl11_top.sv ====
/*
 * dl11 console serial line unit, top level
 * wishbone register port, 8N1 serial line and vectored interrupts
 */
`timescale 1ns/1ps

module dl11_top
   import dl11_pkg::*;
#(
   parameter int unsigned SAMPLE_DIV = 16   // clk cycles per 16x tick
) (
   input  logic         clk,
   input  logic         reset,
   input  iopage_addr_t wb_adr,
   input  word_t        wb_dat_w,
   input  logic [1:0]   wb_sel,
   input  logic         wb_we,
   input  logic         wb_cyc,
   input  logic         wb_stb,
   input  logic         rxd,
   input  logic         interrupt_ack,
   output word_t        wb_dat_r,
   output logic         wb_ack,
   output logic         txd,
   output logic         interrupt,
   output vector_t      vector
);

   logic  sample_tick;
   logic  bit_tick;
   logic  tx_load;
   logic  tx_busy;
   logic  rx_valid;
   logic  rx_unload;
   logic  xbuf_wr;
   logic  rbuf_rd;
   logic  rx_ie;
   logic  tx_ie;
   logic  tx_ready;
   logic  rx_done;
   byte_t rx_byte;
   byte_t xbuf_low;

   dl11_baud_timer #(
      .SAMPLE_DIV (SAMPLE_DIV)
   ) baud_i (
      .clk         (clk),
      .reset       (reset),
      .sample_tick (sample_tick),
      .bit_tick    (bit_tick)
   );

   dl11_tx_shifter tx_i (
      .clk      (clk),
      .reset    (reset),
      .bit_tick (bit_tick),
      .tx_load  (tx_load),
      .tx_byte  (xbuf_low),
      .txd      (txd),
      .tx_busy  (tx_busy)
   );

   dl11_rx_shifter rx_i (
      .clk         (clk),
      .reset       (reset),
      .sample_tick (sample_tick),
      .rxd         (rxd),
      .rx_byte     (rx_byte),
      .rx_valid    (rx_valid)
   );

   dl11_line_ctrl ctrl_i (
      .clk           (clk),
      .reset         (reset),
      .xbuf_wr       (xbuf_wr),
      .rbuf_rd       (rbuf_rd),
      .tx_busy       (tx_busy),
      .rx_valid      (rx_valid),
      .rx_ie         (rx_ie),
      .tx_ie         (tx_ie),
      .interrupt_ack (interrupt_ack),
      .tx_load       (tx_load),
      .rx_unload     (rx_unload),
      .tx_ready      (tx_ready),
      .rx_done       (rx_done),
      .interrupt     (interrupt),
      .vector        (vector)
   );

   dl11_regs regs_i (
      .clk       (clk),
      .reset     (reset),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_sel    (wb_sel),
      .wb_we     (wb_we),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .tx_ready  (tx_ready),
      .rx_done   (rx_done),
      .rx_unload (rx_unload),
      .rx_byte   (rx_byte),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack),
      .xbuf_wr   (xbuf_wr),
      .rbuf_rd   (rbuf_rd),
      .rx_ie     (rx_ie),
      .tx_ie     (tx_ie),
      .xbuf_low  (xbuf_low)
   );

endmodule

// ==== dv/dl11_clkgen.sv ====
/*
 * dl11 testbench clock and reset source
 */
`timescale 1ns/1ps

module dl11_clkgen #(
   parameter int PERIOD       = 8,   // ns
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;   // released on a rising edge
   end

endmodule

// ==== dv/dl11_checker.sv ====
/*
 * dl11 testbench monitor
 * decodes 8N1 frames on txd, compares them and the bus read data
 * with expected values, keeps the error counts
 */
`timescale 1ns/1ps

module dl11_checker
   import dl11_pkg::*;
#(
   parameter int BIT_CYCLES = 32   // clk cycles per serial bit
) (
   input  logic  clk,
   input  logic  reset,
   input  logic  txd,
   input  logic  wb_ack,
   input  word_t wb_dat_r
);

   int    errors = 0;
   int    frames = 0;
   int    reads  = 0;
   byte_t tx_queue[$];   // bytes written to xbuf, oldest first
   logic  armed  = 1'b0;
   word_t exp_word;
   string exp_name;

   function void queue_tx(input byte_t b);
      tx_queue.push_back(b);
   endfunction

   function int pending();
      return tx_queue.size();
   endfunction

   function void expect_read(input string name, input word_t value);
      exp_name = name;
      exp_word = value;
      armed    = 1'b1;
   endfunction

   function void cancel_read();
      armed = 1'b0;
   endfunction

   function void compare_value(input string name, input word_t got, input word_t expected);
      if (got !== expected)
      begin
         errors++;
         $display("mismatch %s: got %h expected %h", name, got, expected);
      end
   endfunction

   function void report_failure(input string msg);
      errors++;
      $display("error: %s", msg);
   endfunction

   // read data is valid while ack is high
   always @(posedge clk)
   begin
      if (armed && wb_ack === 1'b1)
      begin
         armed = 1'b0;
         reads++;
         compare_value({"wb_dat_r ", exp_name}, wb_dat_r, exp_word);
      end
   end

   // txd frame decoder, samples each bit in its middle
   initial
   begin
      byte_t got;
      byte_t expected;
      forever
      begin
         @(posedge clk);
         if (!reset && txd === 1'b0)
         begin
            repeat (BIT_CYCLES / 2 - 1) @(posedge clk);
            if (txd !== 1'b0)
               report_failure("start bit on txd ended early");
            else
            begin
               for (int i = 0; i < 8; i++)
               begin
                  repeat (BIT_CYCLES) @(posedge clk);
                  got[i] = txd;   // lsb first
               end
               repeat (BIT_CYCLES) @(posedge clk);
               frames++;
               if (txd !== 1'b1)
                  report_failure("stop bit on txd was not high");
               if (tx_queue.size() == 0)
                  report_failure("frame seen on txd with no byte written to XBUF");
               else
               begin
                  expected = tx_queue.pop_front();
                  compare_value("txd", {8'h00, got}, {8'h00, expected});
               end
            end
         end
      end
   end

endmodule

// ==== dv/dl11_sva.sv ====
/*
 * dl11 protocol assertions, bus ack and interrupt vector
 */
`timescale 1ns/1ps

module dl11_sva
   import dl11_pkg::*;
(
   input logic    clk,
   input logic    reset,
   input logic    wb_cyc,
   input logic    wb_stb,
   input logic    wb_ack,
   input logic    interrupt,
   input vector_t vector
);

   int fail_count = 0;

   ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
      else begin $error("wb_ack high for more than one cycle"); fail_count++; end

   ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
                                  wb_ack |-> (wb_cyc && wb_stb))
      else begin $error("wb_ack outside a bus cycle"); fail_count++; end

   // a requesting device always presents its vector
   vector_valid: assert property (@(posedge clk) disable iff (reset)
                                  interrupt |-> (vector != '0))
      else begin $error("interrupt high with a zero vector"); fail_count++; end

endmodule

bind dl11_top dl11_sva sva_i (
   .clk       (clk),
   .reset     (reset),
   .wb_cyc    (wb_cyc),
   .wb_stb    (wb_stb),
   .wb_ack    (wb_ack),
   .interrupt (interrupt),
   .vector    (vector)
);

// ==== dv/dl11_tb.sv ====
/*
 * dl11 testbench top
 * table driven bus, serial and interrupt steps against dl11_top
 */
`timescale 1ns/1ps

module dl11_tb
   import dl11_pkg::*;
();

   localparam int unsigned SAMPLE_DIV = 2;
   localparam int BIT_CYCLES = 32;          // 16 samples of SAMPLE_DIV clocks
   localparam int ACK_LIMIT  = 16;
   localparam int POLL_LIMIT = 400;         // status reads
   localparam int IRQ_LIMIT  = 64;
   localparam int WATCHDOG   = 100000;
   localparam iopage_addr_t BAD_ADDR = 13'o17570;

   localparam logic [3:0] OP_WRITE = 4'd0;
   localparam logic [3:0] OP_READ  = 4'd1;
   localparam logic [3:0] OP_POLL  = 4'd2;  // wait for bits in exp
   localparam logic [3:0] OP_SEND  = 4'd3;  // byte on rxd
   localparam logic [3:0] OP_XMIT  = 4'd4;  // xbuf write, byte expected on txd
   localparam logic [3:0] OP_IACK  = 4'd5;
   localparam logic [3:0] OP_NOIRQ = 4'd6;
   localparam logic [3:0] OP_NOACK = 4'd7;

   typedef struct packed {
      logic [3:0]   op;
      iopage_addr_t adr;
      word_t        data;
      logic [1:0]   sel;
      word_t        exp;
   } step_t;

   logic         clk;
   logic         reset;
   iopage_addr_t wb_adr;
   word_t        wb_dat_w;
   word_t        wb_dat_r;
   logic [1:0]   wb_sel;
   logic         wb_we;
   logic         wb_cyc;
   logic         wb_stb;
   logic         wb_ack;
   logic         rxd;
   logic         interrupt_ack;
   logic         txd;
   logic         interrupt;
   vector_t      vector;
   step_t        steps[$];
   integer       seed;
   byte_t        tx_bytes[3] = '{8'h55, 8'ha3, 8'h0f};

   dl11_clkgen clk_i (.clk(clk), .reset(reset));

   dl11_top #(.SAMPLE_DIV(SAMPLE_DIV)) dut_i (
      .clk (clk), .reset (reset),
      .wb_adr (wb_adr), .wb_dat_w (wb_dat_w), .wb_sel (wb_sel), .wb_we (wb_we),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .rxd (rxd), .interrupt_ack (interrupt_ack),
      .wb_dat_r (wb_dat_r), .wb_ack (wb_ack), .txd (txd),
      .interrupt (interrupt), .vector (vector)
   );

   dl11_checker #(.BIT_CYCLES(BIT_CYCLES)) chk_i (
      .clk (clk), .reset (reset), .txd (txd), .wb_ack (wb_ack), .wb_dat_r (wb_dat_r)
   );

   function automatic string reg_name(input iopage_addr_t adr);
      case (adr[12:1])
         RCSR_ADDR[12:1]: return "RCSR";
         RBUF_ADDR[12:1]: return "RBUF";
         XCSR_ADDR[12:1]: return "XCSR";
         XBUF_ADDR[12:1]: return "XBUF";
         default:         return "undecoded";
      endcase
   endfunction

   function void add_step(input logic [3:0] op, input iopage_addr_t adr, input word_t data,
                          input logic [1:0] sel, input word_t exp);
      steps.push_back({op, adr, data, sel, exp});
   endfunction

   function void build_table();
      logic [31:0] rnd;
      byte_t       r;
      add_step(OP_READ, XCSR_ADDR, 0, 2'b11, 16'o200);   // ready, ie clear
      add_step(OP_READ, RCSR_ADDR, 0, 2'b11, 16'o0);
      add_step(OP_NOIRQ, 0, 0, 2'b00, 0);
      foreach (tx_bytes[i])
      begin
         add_step(OP_XMIT, XBUF_ADDR, {8'h00, tx_bytes[i]}, 2'b11, 0);
         add_step(OP_READ, XCSR_ADDR, 0, 2'b11, 16'o0);
         add_step(OP_POLL, XCSR_ADDR, 0, 2'b11, 16'o200);
      end
      for (int i = 0; i < 2; i++)
      begin
         rnd = $random(seed);
         r   = rnd[7:0];
         add_step(OP_SEND, 0, {8'h00, r}, 2'b00, 0);
         add_step(OP_POLL, RCSR_ADDR, 0, 2'b11, 16'o200);
         add_step(OP_READ, RBUF_ADDR, 0, 2'b11, {8'h00, r});
         add_step(OP_READ, RCSR_ADDR, 0, 2'b11, 16'o0);   // done cleared by the read
      end
      // odd byte write, ie taken from the high lane
      add_step(OP_WRITE, XCSR_ADDR + 13'd1, 16'h4000, 2'b10, 0);
      add_step(OP_READ, XCSR_ADDR, 0, 2'b11, 16'o300);
      add_step(OP_WRITE, RCSR_ADDR, 16'o100, 2'b11, 0);
      add_step(OP_READ, RCSR_ADDR, 0, 2'b11, 16'o100);
      rnd = $random(seed);
      r   = rnd[7:0];
      add_step(OP_SEND, 0, {8'h00, r}, 2'b00, 0);
      add_step(OP_POLL, RCSR_ADDR, 0, 2'b11, 16'o200);
      add_step(OP_IACK, 0, 0, 2'b00, {8'h00, RX_VECTOR});   // receive first
      add_step(OP_READ, RBUF_ADDR, 0, 2'b11, {8'h00, r});
      add_step(OP_IACK, 0, 0, 2'b00, {8'h00, TX_VECTOR});
      add_step(OP_XMIT, XBUF_ADDR, 16'h003c, 2'b11, 0);
      add_step(OP_NOIRQ, 0, 0, 2'b00, 0);
      add_step(OP_READ, XCSR_ADDR, 0, 2'b11, 16'o100);
      add_step(OP_POLL, XCSR_ADDR, 0, 2'b11, 16'o200);
      add_step(OP_NOACK, BAD_ADDR, 0, 2'b11, 0);
   endfunction

   task bus_cycle(input iopage_addr_t adr, input word_t data, input logic [1:0] sel,
                  input logic we, input logic check, input word_t exp, output word_t rdata);
      int n;
      @(posedge clk);
      if (check)
         chk_i.expect_read(reg_name(adr), exp);
      wb_adr   <= adr;
      wb_dat_w <= data;
      wb_sel   <= sel;
      wb_we    <= we;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      n = 0;
      @(posedge clk);
      while (wb_ack !== 1'b1 && n < ACK_LIMIT)
      begin
         @(posedge clk);
         n++;
      end
      rdata = wb_dat_r;
      if (wb_ack !== 1'b1)
      begin
         chk_i.cancel_read();
         chk_i.report_failure($sformatf("no ack for %s access to %s",
                                        we ? "write" : "read", reg_name(adr)));
      end
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task poll_done(input iopage_addr_t adr, input word_t bits);
      word_t rdata;
      int    n;
      n = 0;
      bus_cycle(adr, 0, 2'b11, 1'b0, 1'b0, 0, rdata);
      while ((rdata & bits) != bits && n < POLL_LIMIT)
      begin
         bus_cycle(adr, 0, 2'b11, 1'b0, 1'b0, 0, rdata);
         n++;
      end
      if ((rdata & bits) != bits)
         chk_i.report_failure($sformatf("done bit of %s never set", reg_name(adr)));
      else if (adr == XCSR_ADDR && chk_i.pending() != 0)
         chk_i.report_failure("transmitter ready before its frame appeared on txd");
   endtask

   task send_serial(input byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      @(posedge clk);
      for (int i = 0; i < 10; i++)
      begin
         rxd <= frame[i];
         repeat (BIT_CYCLES) @(posedge clk);
      end
   endtask

   task ack_interrupt(input word_t exp);
      int n;
      n = 0;
      @(posedge clk);
      while (interrupt !== 1'b1 && n < IRQ_LIMIT)
      begin
         @(posedge clk);
         n++;
      end
      if (interrupt !== 1'b1)
         chk_i.report_failure("interrupt never asserted");
      else
      begin
         chk_i.compare_value("vector", {8'h00, vector}, exp);
         interrupt_ack <= 1'b1;
         @(posedge clk);
         interrupt_ack <= 1'b0;
      end
   endtask

   task expect_no_interrupt();
      int n;
      n = 0;
      @(posedge clk);
      while (interrupt !== 1'b0 && n < IRQ_LIMIT)
      begin
         @(posedge clk);
         n++;
      end
      if (interrupt !== 1'b0)
         chk_i.report_failure("interrupt stayed high");
   endtask

   // a miss must never be acknowledged
   task probe_undecoded(input iopage_addr_t adr);
      logic seen;
      seen = 1'b0;
      @(posedge clk);
      wb_adr <= adr;
      wb_we  <= 1'b0;
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      for (int n = 0; n < ACK_LIMIT; n++)
      begin
         @(posedge clk);
         if (wb_ack === 1'b1)
            seen = 1'b1;
      end
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      if (seen)
         chk_i.report_failure($sformatf("undecoded address %o was acknowledged", adr));
   endtask

   initial
   begin
      repeat (WATCHDOG) @(posedge clk);
      $display("simulation did not finish within %0d cycles", WATCHDOG);
      $display("** FAIL **");
      $finish;
   end

   initial
   begin
      step_t s;
      word_t rdata;
      int    n;
      int    total;
      seed          = 32'h7efa_8c50;
      wb_adr        = '0;
      wb_dat_w      = '0;
      wb_sel        = 2'b00;
      wb_we         = 1'b0;
      wb_cyc        = 1'b0;
      wb_stb        = 1'b0;
      rxd           = 1'b1;   // mark
      interrupt_ack = 1'b0;
      build_table();
      n = 0;
      @(posedge clk);
      while (reset !== 1'b0 && n < 16)
      begin
         @(posedge clk);
         n++;
      end
      if (reset !== 1'b0)
         chk_i.report_failure("reset never released");
      foreach (steps[i])
      begin
         s = steps[i];
         case (s.op)
            OP_WRITE: bus_cycle(s.adr, s.data, s.sel, 1'b1, 1'b0, 0, rdata);
            OP_READ:  bus_cycle(s.adr, 0, s.sel, 1'b0, 1'b1, s.exp, rdata);
            OP_POLL:  poll_done(s.adr, s.exp);
            OP_SEND:  send_serial(s.data[7:0]);
            OP_XMIT:
            begin
               chk_i.queue_tx(s.data[7:0]);
               bus_cycle(s.adr, s.data, s.sel, 1'b1, 1'b0, 0, rdata);
            end
            OP_IACK:  ack_interrupt(s.exp);
            OP_NOIRQ: expect_no_interrupt();
            OP_NOACK: probe_undecoded(s.adr);
            default:  chk_i.report_failure("unknown step in the stimulus table");
         endcase
      end
      if (chk_i.pending() != 0)
         chk_i.report_failure("bytes written to XBUF never appeared on txd");
      total = chk_i.errors + dut_i.sva_i.fail_count;
      $display("errors %0d, assertion failures %0d, frames %0d, reads %0d",
               chk_i.errors, dut_i.sva_i.fail_count, chk_i.frames, chk_i.reads);
      if (total == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== files.f ====
design/dl11_pkg.sv
design/dl11_baud_timer.sv
design/dl11_tx_shifter.sv
design/dl11_rx_shifter.sv
design/dl11_line_ctrl.sv
design/dl11_regs.sv
design/dl11_top.sv
dv/dl11_clkgen.sv
dv/dl11_checker.sv
dv/dl11_sva.sv
dv/dl11_tb.sv
